//--- verilog/ps2_kbd_defs.svh
`ifndef PS2_KBD_DEFS_SVH
`define PS2_KBD_DEFS_SVH

// Set 2 scan codes
`define SC_BREAK        8'hF0

// Player 1 keys
`define SC_E            8'h24
`define SC_W            8'h1D
`define SC_A            8'h1C
`define SC_S            8'h1B
`define SC_D            8'h23

// Player 2 keys, numeric keypad
`define SC_KP7          8'h6C
`define SC_KP8          8'h75
`define SC_KP4          8'h6B
`define SC_KP5          8'h73
`define SC_KP6          8'h74

// Register map, addresses 0 to 9 are single keys
`define ADDR_KEY_LAST   4'd9
`define ADDR_P1         4'd10
`define ADDR_P2         4'd11
`define ADDR_ALL        4'd12
`define ADDR_STATUS     4'd13

// Host bus widths
`define ADDR_W          4
`define DATA_W          16

`endif

//--- verilog/ps2_pkg.sv
package ps2_pkg;

        // Data bits carried by one PS/2 frame
        localparam int DATA_BITS = 8;

        typedef logic [DATA_BITS-1:0] scan_code_t;

        typedef logic [$clog2(DATA_BITS)-1:0] bit_cnt_t;

        // Receiver phase, the start bit is taken in IDLE
        typedef enum logic [1:0] {
                IDLE   = 2'd0,
                DATA   = 2'd1,
                PARITY = 2'd2,
                STOP   = 2'd3
        } rx_state_t;

endpackage

//--- verilog/key_pkg.sv
package key_pkg;

        localparam int NUM_KEYS = 10;

        // Flat bit positions of the tracked keys
        typedef enum logic [3:0] {
                KEY_E   = 4'd0,
                KEY_W   = 4'd1,
                KEY_A   = 4'd2,
                KEY_S   = 4'd3,
                KEY_D   = 4'd4,
                KEY_KP7 = 4'd5,
                KEY_KP8 = 4'd6,
                KEY_KP4 = 4'd7,
                KEY_KP5 = 4'd8,
                KEY_KP6 = 4'd9
        } key_idx_t;

        // Declared MSB first so that fire lands on the lowest flat index
        typedef struct packed {
                logic right;
                logic down;
                logic left;
                logic up;
                logic fire;
        } player_keys_t;

        typedef union packed {
                logic [NUM_KEYS-1:0] flat;
                struct packed {
                        player_keys_t p2;
                        player_keys_t p1;
                } players;
        } key_state_u;

endpackage

//--- verilog/ps2_rx.sv
module ps2_rx (
        input  logic                clk,
        input  logic                rst,
        input  logic                ps2_clk,
        input  logic                ps2_data,
        output ps2_pkg::scan_code_t code,
        output logic                code_valid,
        output logic                frame_err
);

        // Longest gap between two PS/2 clock edges inside a frame
        localparam logic [9:0] TIMEOUT = 10'd1023;

        logic [1:0]          clk_sync;
        logic [1:0]          data_sync;
        logic                clk_prev;
        logic                fall;
        logic                bit_in;
        ps2_pkg::rx_state_t  state;
        ps2_pkg::bit_cnt_t   bit_cnt;
        ps2_pkg::scan_code_t shift;
        logic                start_ok;
        logic                parity_bit;
        logic                stop_ok;
        logic                frame_done;
        logic [9:0]          idle_cnt;
        logic                frame_ok;

        // Both lines idle high, so reset them high to avoid a false edge
        always_ff @(posedge clk) begin
                if (rst) begin
                        clk_sync  <= 2'b11;
                        data_sync <= 2'b11;
                        clk_prev  <= 1'b1;
                        fall      <= 1'b0;
                end else begin
                        clk_sync  <= {clk_sync[0], ps2_clk};
                        data_sync <= {data_sync[0], ps2_data};
                        clk_prev  <= clk_sync[1];
                        fall      <= clk_prev & ~clk_sync[1];
                end
        end

        // Data bit as seen together with the falling edge
        always_ff @(posedge clk) begin
                bit_in <= data_sync[1];
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state      <= ps2_pkg::IDLE;
                        bit_cnt    <= '0;
                        idle_cnt   <= '0;
                        frame_done <= 1'b0;
                end else begin
                        frame_done <= 1'b0;
                        if (fall || state == ps2_pkg::IDLE) begin
                                idle_cnt <= '0;
                        end else if (idle_cnt != TIMEOUT) begin
                                idle_cnt <= idle_cnt + 1'b1;
                        end

                        if (fall) begin
                                case (state)
                                        ps2_pkg::IDLE: begin
                                                state   <= ps2_pkg::DATA;
                                                bit_cnt <= '0;
                                        end
                                        ps2_pkg::DATA: begin
                                                bit_cnt <= bit_cnt + 1'b1;
                                                if (bit_cnt == ps2_pkg::bit_cnt_t'(ps2_pkg::DATA_BITS - 1)) begin
                                                        state <= ps2_pkg::PARITY;
                                                end
                                        end
                                        ps2_pkg::PARITY: begin
                                                state <= ps2_pkg::STOP;
                                        end
                                        ps2_pkg::STOP: begin
                                                state      <= ps2_pkg::IDLE;
                                                frame_done <= 1'b1;
                                        end
                                endcase
                        end else if (idle_cnt == TIMEOUT) begin
                                // Half frame, give up and wait for a new start bit
                                state <= ps2_pkg::IDLE;
                        end
                end
        end

        // LSB first, so each new bit enters at the top
        always_ff @(posedge clk) begin
                if (fall) begin
                        case (state)
                                ps2_pkg::IDLE:   start_ok   <= ~bit_in;
                                ps2_pkg::DATA:   shift      <= {bit_in, shift[7:1]};
                                ps2_pkg::PARITY: parity_bit <= bit_in;
                                ps2_pkg::STOP:   stop_ok    <= bit_in;
                        endcase
                end
        end

        // Odd parity over data and parity bit
        assign frame_ok = start_ok & stop_ok & (^{parity_bit, shift});

        always_ff @(posedge clk) begin
                if (rst) begin
                        code_valid <= 1'b0;
                        frame_err  <= 1'b0;
                end else begin
                        code_valid <= frame_done & frame_ok;
                        frame_err  <= frame_done & ~frame_ok;
                end
        end

        // Shift register is quiet until the next frame starts
        assign code = shift;

endmodule

//--- verilog/scan_tracker.sv
`include "ps2_kbd_defs.svh"

module scan_tracker (
        input  logic                clk,
        input  logic                rst,
        input  ps2_pkg::scan_code_t code,
        input  logic                code_valid,
        output key_pkg::key_state_u keys,
        output ps2_pkg::scan_code_t last_code
);

        logic              break_flag;
        logic              is_break;
        logic              key_hit;
        key_pkg::key_idx_t key_idx;

        assign is_break = (code == `SC_BREAK);

        // Scan code to key position
        always_comb begin
                key_hit = 1'b1;
                key_idx = key_pkg::KEY_E;
                case (code)
                        `SC_E: begin
                                key_idx = key_pkg::KEY_E;
                        end
                        `SC_W: begin
                                key_idx = key_pkg::KEY_W;
                        end
                        `SC_A: begin
                                key_idx = key_pkg::KEY_A;
                        end
                        `SC_S: begin
                                key_idx = key_pkg::KEY_S;
                        end
                        `SC_D: begin
                                key_idx = key_pkg::KEY_D;
                        end
                        `SC_KP7: begin
                                key_idx = key_pkg::KEY_KP7;
                        end
                        `SC_KP8: begin
                                key_idx = key_pkg::KEY_KP8;
                        end
                        `SC_KP4: begin
                                key_idx = key_pkg::KEY_KP4;
                        end
                        `SC_KP5: begin
                                key_idx = key_pkg::KEY_KP5;
                        end
                        `SC_KP6: begin
                                key_idx = key_pkg::KEY_KP6;
                        end
                        default: begin
                                key_hit = 1'b0;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        keys.flat  <= '0;
                        break_flag <= 1'b0;
                        last_code  <= '0;
                end else if (code_valid) begin
                        last_code <= code;
                        if (is_break) begin
                                break_flag <= 1'b1;
                        end else begin
                                // Prefix applies to the very next code only
                                break_flag <= 1'b0;
                                if (key_hit) begin
                                        keys.flat[key_idx] <= ~break_flag;
                                end
                        end
                end
        end

endmodule

//--- verilog/key_read_port.sv
`include "ps2_kbd_defs.svh"

module key_read_port (
        input  logic                clk,
        input  logic                rst,
        input  logic                rd,
        input  logic [`ADDR_W-1:0]  addr,
        input  logic                frame_err,
        input  key_pkg::key_state_u keys,
        input  ps2_pkg::scan_code_t last_code,
        output logic [`DATA_W-1:0]  rdata,
        output logic                rdata_valid
);

        logic [7:0]         err_cnt;
        logic [`DATA_W-1:0] rd_word;

        // Dropped frames, stops at 255
        always_ff @(posedge clk) begin
                if (rst) begin
                        err_cnt <= '0;
                end else if (frame_err && err_cnt != 8'hFF) begin
                        err_cnt <= err_cnt + 1'b1;
                end
        end

        always_comb begin
                rd_word = '0;
                if (addr <= `ADDR_KEY_LAST) begin
                        rd_word[0] = keys.flat[key_pkg::key_idx_t'(addr)];
                end else begin
                        case (addr)
                                `ADDR_P1:     rd_word[4:0] = keys.players.p1;
                                `ADDR_P2:     rd_word[4:0] = keys.players.p2;
                                `ADDR_ALL:    rd_word[key_pkg::NUM_KEYS-1:0] = keys.flat;
                                `ADDR_STATUS: rd_word = {err_cnt, last_code};
                                default:      rd_word = '0;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        rdata_valid <= 1'b0;
                end else begin
                        rdata_valid <= rd;
                end
        end

        // Held between reads
        always_ff @(posedge clk) begin
                if (rd) begin
                        rdata <= rd_word;
                end
        end

endmodule

//--- verilog/ps2_keypad_ctrl.sv
`include "ps2_kbd_defs.svh"

module ps2_keypad_ctrl (
        input  logic               clk,
        input  logic               rst,
        input  logic               ps2_clk,
        input  logic               ps2_data,
        input  logic               rd,
        input  logic [`ADDR_W-1:0] addr,
        output logic [`DATA_W-1:0] rdata,
        output logic               rdata_valid
);

        ps2_pkg::scan_code_t code;
        logic                code_valid;
        logic                frame_err;
        key_pkg::key_state_u keys;
        ps2_pkg::scan_code_t last_code;

        ps2_rx i_rx (
                .clk        (clk),
                .rst        (rst),
                .ps2_clk    (ps2_clk),
                .ps2_data   (ps2_data),
                .code       (code),
                .code_valid (code_valid),
                .frame_err  (frame_err)
        );

        scan_tracker i_tracker (
                .clk        (clk),
                .rst        (rst),
                .code       (code),
                .code_valid (code_valid),
                .keys       (keys),
                .last_code  (last_code)
        );

        key_read_port i_read_port (
                .clk         (clk),
                .rst         (rst),
                .rd          (rd),
                .addr        (addr),
                .frame_err   (frame_err),
                .keys        (keys),
                .last_code   (last_code),
                .rdata       (rdata),
                .rdata_valid (rdata_valid)
        );

endmodule

//--- dv/ps2_keypad_properties.sv
module ps2_keypad_properties (
        input logic clk,
        input logic rst,
        input logic rd,
        input logic rdata_valid,
        input logic code_valid,
        input logic frame_err
);

        timeunit 1ns;
        timeprecision 100ps;

        int fail_count = 0;

        // Read strobe is answered in exactly one cycle
        rd_to_valid: assert property (@(posedge clk) disable iff (rst) rdata_valid == $past(rd))
                else begin
                        $error("rdata_valid does not follow rd by one cycle");
                        fail_count++;
                end

        good_or_bad: assert property (@(posedge clk) disable iff (rst) !(code_valid && frame_err))
                else begin
                        $error("code_valid and frame_err high in the same cycle");
                        fail_count++;
                end

        quiet_after_reset: assert property (@(posedge clk)
                        rst |=> !code_valid && !frame_err && !rdata_valid)
                else begin
                        $error("Strobe high right after reset");
                        fail_count++;
                end

endmodule

//--- dv/ps2_keypad_tb.sv
`include "ps2_kbd_defs.svh"

module ps2_keypad_tb;

        timeunit 1ns;
        timeprecision 100ps;

        logic               clk;
        logic               rst = 1'b1;
        logic               ps2_clk = 1'b1;
        logic               ps2_data = 1'b1;
        logic               rd = 1'b0;
        logic [`ADDR_W-1:0] addr = '0;
        logic [`DATA_W-1:0] rdata;
        logic               rdata_valid;

        // Reference model of the controller state
        logic [9:0]         ref_keys = '0;
        logic               ref_break = 1'b0;
        logic [7:0]         ref_errs = '0;
        logic [7:0]         ref_last = '0;

        logic [`DATA_W-1:0] exp_q[$];
        string              name_q[$];
        string              test_name;
        integer             seed = 32'hdb9db719;

        ps2_keypad_ctrl i_dut (
                .clk         (clk),
                .rst         (rst),
                .ps2_clk     (ps2_clk),
                .ps2_data    (ps2_data),
                .rd          (rd),
                .addr        (addr),
                .rdata       (rdata),
                .rdata_valid (rdata_valid)
        );

        bind ps2_keypad_ctrl ps2_keypad_properties i_props (
                .clk         (clk),
                .rst         (rst),
                .rd          (rd),
                .rdata_valid (rdata_valid),
                .code_valid  (code_valid),
                .frame_err   (frame_err)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // Key order E W A S D, then KP7 KP8 KP4 KP5 KP6
        function automatic logic [7:0] code_of(input int idx);
                case (idx)
                        0: return `SC_E;
                        1: return `SC_W;
                        2: return `SC_A;
                        3: return `SC_S;
                        4: return `SC_D;
                        5: return `SC_KP7;
                        6: return `SC_KP8;
                        7: return `SC_KP4;
                        8: return `SC_KP5;
                        default: return `SC_KP6;
                endcase
        endfunction

        function automatic int key_index(input logic [7:0] code);
                for (int i = 0; i < 10; i++) begin
                        if (code_of(i) == code) begin
                                return i;
                        end
                end
                return -1;
        endfunction

        function automatic logic [`DATA_W-1:0] expected_rdata(input logic [`ADDR_W-1:0] a);
                if (a <= `ADDR_KEY_LAST) begin
                        return {15'd0, ref_keys[a]};
                end
                case (a)
                        `ADDR_P1:     return {11'd0, ref_keys[4:0]};
                        `ADDR_P2:     return {11'd0, ref_keys[9:5]};
                        `ADDR_ALL:    return {6'd0, ref_keys};
                        `ADDR_STATUS: return {ref_errs, ref_last};
                        default:      return 16'd0;
                endcase
        endfunction

        task automatic stop_run(input string why);
                $display("%s", why);
                $display("Testbench failed");
                $fatal(1, "Run stopped at the first error");
        endtask

        task automatic check_value(input string name, input logic [`DATA_W-1:0] expected,
                                   input logic [`DATA_W-1:0] actual);
                if (actual !== expected) begin
                        stop_run($sformatf("Mismatch %s expected %h actual %h",
                                           name, expected, actual));
                end
        endtask

        // Data changes while the PS/2 clock is high and is sampled on the fall
        task automatic send_frame(input logic [7:0] code, input logic bad_parity,
                                  input logic bad_stop);
                logic [10:0] bits;
                logic        seen;
                logic        seen_err;
                bits = {~bad_stop, (~^code) ^ bad_parity, code, 1'b0};
                seen = 1'b0;
                seen_err = 1'b0;
                for (int i = 0; i < 11; i++) begin
                        @(posedge clk);
                        ps2_data <= bits[i];
                        repeat (19) @(posedge clk);
                        ps2_clk <= 1'b0;
                        // Low half of the stop bit also waits for the receiver strobe
                        for (int n = 0; n < 20; n++) begin
                                @(posedge clk);
                                if (i == 10 && (i_dut.code_valid || i_dut.frame_err)) begin
                                        seen = 1'b1;
                                        seen_err = i_dut.frame_err;
                                end
                        end
                        ps2_clk <= 1'b1;
                end
                @(posedge clk);
                ps2_data <= 1'b1;
                if (!seen) begin
                        stop_run("Receiver gave no strobe within 20 cycles of the stop bit");
                end
                check_value($sformatf("%s frame_err", test_name),
                            {15'd0, bad_parity | bad_stop}, {15'd0, seen_err});
                if (bad_parity || bad_stop) begin
                        if (ref_errs != 8'hFF) begin
                                ref_errs = ref_errs + 8'd1;
                        end
                end else begin
                        ref_last = code;
                        if (code == `SC_BREAK) begin
                                ref_break = 1'b1;
                        end else begin
                                if (key_index(code) >= 0) begin
                                        ref_keys[key_index(code)] = ~ref_break;
                                end
                                ref_break = 1'b0;
                        end
                end
        endtask

        task automatic read_reg(input logic [`ADDR_W-1:0] a);
                @(posedge clk);
                rd   <= 1'b1;
                addr <= a;
                exp_q.push_back(expected_rdata(a));
                name_q.push_back($sformatf("%s addr %0d", test_name, a));
                @(posedge clk);
                rd <= 1'b0;
        endtask

        task automatic wait_reads_done();
                int n;
                n = 0;
                while (exp_q.size() != 0 && n < 10) begin
                        @(posedge clk);
                        n++;
                end
                if (exp_q.size() != 0) begin
                        stop_run("Read data did not return within 10 cycles");
                end
        endtask

        task automatic read_range(input int first, input int last);
                for (int a = first; a <= last; a++) begin
                        read_reg(a[3:0]);
                end
                wait_reads_done();
        endtask

        // Compares every returned read with the value expected when it was issued
        initial begin
                forever begin
                        @(posedge clk);
                        if (i_dut.i_props.fail_count != 0) begin
                                stop_run("A bound assertion on the DUT failed");
                        end
                        if (rdata_valid === 1'b1) begin
                                if (exp_q.size() == 0) begin
                                        stop_run("rdata_valid pulsed with no read pending");
                                end else begin
                                        check_value(name_q.pop_front(), exp_q.pop_front(), rdata);
                                end
                        end
                end
        end

        initial begin
                int         sel;
                logic [7:0] code;
                repeat (3) @(posedge clk);
                rst <= 1'b0;

                test_name = "reset";
                read_range(0, 13);

                test_name = "make";
                send_frame(`SC_E, 1'b0, 1'b0);
                send_frame(`SC_A, 1'b0, 1'b0);
                send_frame(`SC_KP5, 1'b0, 1'b0);
                read_range(0, 13);

                test_name = "break";
                send_frame(`SC_BREAK, 1'b0, 1'b0);
                send_frame(`SC_A, 1'b0, 1'b0);
                send_frame(`SC_E, 1'b0, 1'b0);
                read_range(0, 13);

                test_name = "unknown after break";
                send_frame(`SC_BREAK, 1'b0, 1'b0);
                send_frame(8'h55, 1'b0, 1'b0);
                send_frame(`SC_W, 1'b0, 1'b0);
                read_range(0, 13);

                test_name = "bad frames";
                send_frame(`SC_S, 1'b1, 1'b0);
                send_frame(`SC_D, 1'b0, 1'b1);
                read_range(`ADDR_ALL, `ADDR_STATUS);

                test_name = "random";
                for (int i = 0; i < 200; i++) begin
                        sel = int'($unsigned($random(seed)) % 16);
                        if (sel < 10) begin
                                code = code_of(sel);
                        end else if (sel < 13) begin
                                code = `SC_BREAK;
                        end else begin
                                code = 8'($random(seed));
                        end
                        send_frame(code, 1'b0, 1'b0);
                end
                read_range(0, 15);

                wait_reads_done();
                if (i_dut.i_props.fail_count == 0) begin
                        $display("Testbench passed");
                        $finish;
                end else begin
                        stop_run("A bound assertion on the DUT failed");
                end
        end

endmodule

//--- all.f
+incdir+verilog
verilog/ps2_pkg.sv
verilog/key_pkg.sv
verilog/ps2_rx.sv
verilog/scan_tracker.sv
verilog/key_read_port.sv
verilog/ps2_keypad_ctrl.sv
dv/ps2_keypad_properties.sv
dv/ps2_keypad_tb.sv

//--- Makefile
TOP = ps2_keypad_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
